// ==== common/pcie_app_defines.svh ====
`ifndef PCIE_APP_DEFINES_SVH
`define PCIE_APP_DEFINES_SVH

// TLP beat geometry
`define TLP_DW          4
`define TLP_W           128

// BAR hit vector from the core, one-hot
`define BAR_W           6
`define BAR1_BIT        1
`define BAR3_BIT        3

// Bus and device number from config space
`define BUSDEV_W        13

// BAR3 RAM size in dword address bits
`define MEM_AW          8
// Completion queue entries per target, power of two
`define CPL_Q_DEPTH     2

// Start counter top bit sets after 2**START_DLY_W cycles
`define START_DLY_W     4
`define RUN_DLY         23

// Header fmt and type codes
`define FMT_3DW_NODATA  3'b000
`define FMT_3DW_DATA    3'b010
`define TYP_MEM         5'b00000
`define TYP_CPL         5'b01010

// BAR1 register map, dword offsets
`define APP_ID          32'h5043_4941
`define REG_ID          0
`define REG_SCRATCH     1
`define REG_STATUS      2

`endif

// ==== common/pcie_app_pkg.sv ====
`include "pcie_app_defines.svh"

package pcie_app_pkg;

    // One TLP beat, dword 0 in the low bits
    typedef struct packed {
        logic                   sop;
        logic                   eop;
        logic [`TLP_DW-1:0]     valid;
        logic [`TLP_W-1:0]      data;
    } tlp_beat_t;

    // Decoded one-dword memory request
    typedef struct packed {
        logic                   valid;
        logic                   wr;
        logic [`MEM_AW-1:0]     addr;
        logic [15:0]            req_id;
        logic [7:0]             tag;
        logic [6:0]             lower_addr;
        logic [31:0]            data;
    } tlp_req_t;

    // Queued completion, enough to rebuild the CplD header
    typedef struct packed {
        logic [15:0]            req_id;
        logic [7:0]             tag;
        logic [6:0]             lower_addr;
        logic [31:0]            data;
    } cpl_info_t;

    // One-dword CplD in a single beat
    function automatic tlp_beat_t build_cpl_beat(
        input cpl_info_t             info,
        input logic [`BUSDEV_W-1:0]  busdev
    );
        tlp_beat_t beat;
        beat.sop   = 1'b1;
        beat.eop   = 1'b1;
        beat.valid = {`TLP_DW{1'b1}};
        // Fmt, type, no TC or attributes, length 1
        beat.data[31:0]   = {`FMT_3DW_DATA, `TYP_CPL, 8'h00, 6'h00, 10'd1};
        // Completer ID is bus/device with function 0
        // Status successful, byte count 4
        beat.data[63:32]  = {busdev, 3'b000, 3'b000, 1'b0, 12'd4};
        beat.data[95:64]  = {info.req_id, info.tag, 1'b0, info.lower_addr};
        beat.data[127:96] = info.data;
        return beat;
    endfunction

endpackage

// ==== hdl/start_delay_ctrl.sv ====
`timescale 1ns/100ps
`include "pcie_app_defines.svh"

module start_delay_ctrl (
    input  logic        cfg_clk,
    input  logic        rstn,
    input  logic        link_up_i,
    output logic        tlp_rstn_o,
    output logic [2:0]  led_o
);

    logic [`START_DLY_W:0]  st_cnt;
    logic [`RUN_DLY:0]      run_cnt;
    logic                   started;
    logic                   link_r;

    // Top bit set means the TLP logic may run
    assign started = st_cnt[`START_DLY_W];

    // Counts up once, then holds
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            st_cnt <= '0;
        end else if (!started) begin
            st_cnt <= st_cnt + 1'b1;
        end
    end

    // Free running, only for the blink
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            run_cnt <= '0;
        end else begin
            run_cnt <= run_cnt + 1'b1;
        end
    end

    // Link status into cfg_clk
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            link_r <= 1'b0;
        end else begin
            link_r <= link_up_i;
        end
    end

    assign tlp_rstn_o = started;

    // Run blink, waiting for start, link down
    assign led_o[0] = run_cnt[`RUN_DLY];
    assign led_o[1] = ~started;
    assign led_o[2] = ~link_r;

    // Once released the TLP reset stays released until rstn drops
    a_tlp_rstn_hold: assert property (@(posedge cfg_clk) disable iff (!rstn)
        tlp_rstn_o |=> tlp_rstn_o);

endmodule

// ==== rx/tlp_bar_demux.sv ====
`timescale 1ns/100ps
`include "pcie_app_defines.svh"

module tlp_bar_demux import pcie_app_pkg::*; (
    input  logic                cfg_clk,
    input  logic                rstn,
    input  tlp_beat_t           beat_i,
    input  logic [`BAR_W-1:0]   bardec_i,
    output tlp_beat_t           reg_beat_o,
    output tlp_beat_t           mem_beat_o
);

    logic   hit_reg;
    logic   hit_mem;

    // Single-beat TLPs only, so the sop beat is the whole packet
    assign hit_reg = beat_i.sop && bardec_i[`BAR1_BIT];
    assign hit_mem = beat_i.sop && bardec_i[`BAR3_BIT];

    // Register and steer; an idle output is all zero
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            reg_beat_o <= '0;
            mem_beat_o <= '0;
        end else begin
            reg_beat_o <= hit_reg ? beat_i : '0;
            mem_beat_o <= hit_mem ? beat_i : '0;
        end
    end

    // Core marks at most one BAR per packet
    a_bar_onehot: assert property (@(posedge cfg_clk) disable iff (!rstn)
        beat_i.sop |-> $onehot0(bardec_i));

endmodule

// ==== rx/tlp_hdr_dec.sv ====
`timescale 1ns/100ps
`include "pcie_app_defines.svh"

module tlp_hdr_dec import pcie_app_pkg::*; (
    input  logic        cfg_clk,
    input  logic        rstn,
    input  tlp_beat_t   beat_i,
    output tlp_req_t    req_o
);

    logic [31:0]    hdr0;
    logic [31:0]    hdr1;
    logic [31:0]    hdr2;
    logic [31:0]    pld;
    logic [2:0]     fmt;
    logic [4:0]     typ;
    logic           one_dw;
    logic           mem_rd;
    logic           mem_wr;

    // 3DW header in dwords 0 to 2, write data in dword 3
    assign hdr0 = beat_i.data[31:0];
    assign hdr1 = beat_i.data[63:32];
    assign hdr2 = beat_i.data[95:64];
    assign pld  = beat_i.data[127:96];

    assign fmt = hdr0[31:29];
    assign typ = hdr0[28:24];

    // Whole packet in one beat, length field 1
    assign one_dw = beat_i.sop && beat_i.eop && (hdr0[9:0] == 10'd1);

    // Read carries three header dwords
    assign mem_rd = (fmt == `FMT_3DW_NODATA) && (typ == `TYP_MEM)
                    && (beat_i.valid[2:0] == 3'b111);
    // Write also needs the data dword
    assign mem_wr = (fmt == `FMT_3DW_DATA) && (typ == `TYP_MEM)
                    && (beat_i.valid == {`TLP_DW{1'b1}});

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            req_o <= '0;
        end else begin
            // Anything else is dropped here
            req_o.valid      <= one_dw && (mem_rd || mem_wr);
            req_o.wr         <= mem_wr;
            req_o.addr       <= hdr2[`MEM_AW+1:2];
            req_o.req_id     <= hdr1[31:16];
            req_o.tag        <= hdr1[15:8];
            // Dword aligned, byte offset zero
            req_o.lower_addr <= {hdr2[6:2], 2'b00};
            req_o.data       <= pld;
        end
    end

endmodule

// ==== bar/bar_mem_target.sv ====
`timescale 1ns/100ps
`include "pcie_app_defines.svh"

module bar_mem_target import pcie_app_pkg::*; (
    input  logic                    cfg_clk,
    input  logic                    rstn,
    input  tlp_req_t                req_i,
    input  logic [`BUSDEV_W-1:0]    busdev_i,
    output logic                    cpl_req_o,
    output tlp_beat_t               cpl_beat_o,
    input  logic                    cpl_grant_i
);

    localparam int QW = $clog2(`CPL_Q_DEPTH);

    // MMIO test RAM
    logic [31:0]    mem [2**`MEM_AW];

    // Read stage ahead of the queue
    logic           rd_pend;
    cpl_info_t      rd_info;

    // Completion queue
    cpl_info_t      q_mem [`CPL_Q_DEPTH];
    logic [QW-1:0]  wr_ptr;
    logic [QW-1:0]  rd_ptr;
    logic [QW:0]    q_cnt;
    logic           q_full;
    logic           q_empty;
    logic           push;
    logic           pop;

    // RAM write and registered read, header fields ride along
    always_ff @(posedge cfg_clk) begin
        if (req_i.valid && req_i.wr) begin
            mem[req_i.addr] <= req_i.data;
        end
        rd_info.req_id     <= req_i.req_id;
        rd_info.tag        <= req_i.tag;
        rd_info.lower_addr <= req_i.lower_addr;
        rd_info.data       <= mem[req_i.addr];
    end

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            rd_pend <= 1'b0;
        end else begin
            rd_pend <= req_i.valid && !req_i.wr;
        end
    end

    assign q_full  = (q_cnt == (QW+1)'(`CPL_Q_DEPTH));
    assign q_empty = (q_cnt == '0);
    assign push    = rd_pend && !q_full;
    assign pop     = cpl_grant_i && !q_empty;

    always_ff @(posedge cfg_clk) begin
        if (push) begin
            q_mem[wr_ptr] <= rd_info;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    // Head entry is offered until granted
    assign cpl_req_o  = !q_empty;
    assign cpl_beat_o = build_cpl_beat(q_mem[rd_ptr], busdev_i);

    // Host sent more reads than we have completion slots
    a_no_push_full: assert property (@(posedge cfg_clk) disable iff (!rstn)
        !(rd_pend && q_full));

    // Arbiter must only grant a pending completion
    a_grant_req: assert property (@(posedge cfg_clk) disable iff (!rstn)
        cpl_grant_i |-> cpl_req_o);

endmodule

// ==== bar/bar_reg_target.sv ====
`timescale 1ns/100ps
`include "pcie_app_defines.svh"

module bar_reg_target import pcie_app_pkg::*; (
    input  logic                    cfg_clk,
    input  logic                    rstn,
    input  tlp_req_t                req_i,
    input  logic [`BUSDEV_W-1:0]    busdev_i,
    input  logic                    link_up_i,
    output logic                    cpl_req_o,
    output tlp_beat_t               cpl_beat_o,
    input  logic                    cpl_grant_i
);

    localparam int QW = $clog2(`CPL_Q_DEPTH);

    logic [31:0]    scratch_q;
    logic [31:0]    reg_rdata;

    logic           rd_pend;
    cpl_info_t      rd_info;

    cpl_info_t      q_mem [`CPL_Q_DEPTH];
    logic [QW-1:0]  wr_ptr;
    logic [QW-1:0]  rd_ptr;
    logic [QW:0]    q_cnt;
    logic           q_full;
    logic           q_empty;
    logic           push;
    logic           pop;

    // Read map; unmapped offsets return zero
    always_comb begin
        case (req_i.addr)
            `REG_ID:      reg_rdata = `APP_ID;
            `REG_SCRATCH: reg_rdata = scratch_q;
            `REG_STATUS:  reg_rdata = {31'd0, link_up_i};
            default:      reg_rdata = '0;
        endcase
    end

    // Only scratch is writable
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            scratch_q <= '0;
            rd_pend   <= 1'b0;
        end else begin
            if (req_i.valid && req_i.wr && (req_i.addr == `REG_SCRATCH)) begin
                scratch_q <= req_i.data;
            end
            rd_pend <= req_i.valid && !req_i.wr;
        end
    end

    always_ff @(posedge cfg_clk) begin
        rd_info.req_id     <= req_i.req_id;
        rd_info.tag        <= req_i.tag;
        rd_info.lower_addr <= req_i.lower_addr;
        rd_info.data       <= reg_rdata;
    end

    assign q_full  = (q_cnt == (QW+1)'(`CPL_Q_DEPTH));
    assign q_empty = (q_cnt == '0);
    assign push    = rd_pend && !q_full;
    assign pop     = cpl_grant_i && !q_empty;

    always_ff @(posedge cfg_clk) begin
        if (push) begin
            q_mem[wr_ptr] <= rd_info;
        end
    end

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            q_cnt  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   q_cnt <= q_cnt + 1'b1;
                2'b01:   q_cnt <= q_cnt - 1'b1;
                default: q_cnt <= q_cnt;
            endcase
        end
    end

    assign cpl_req_o  = !q_empty;
    assign cpl_beat_o = build_cpl_beat(q_mem[rd_ptr], busdev_i);

    // Read overflow is a host protocol error
    a_no_push_full: assert property (@(posedge cfg_clk) disable iff (!rstn)
        !(rd_pend && q_full));

    a_grant_req: assert property (@(posedge cfg_clk) disable iff (!rstn)
        cpl_grant_i |-> cpl_req_o);

endmodule

// ==== hdl/tx_cpl_arb.sv ====
`timescale 1ns/100ps

module tx_cpl_arb import pcie_app_pkg::*; (
    input  logic            cfg_clk,
    input  logic            rstn,
    input  logic            tx_wait_i,
    input  logic            link_up_i,
    input  logic [1:0]      cpl_req_i,
    input  tlp_beat_t [1:0] cpl_beat_i,
    output logic [1:0]      cpl_grant_o,
    output tlp_beat_t       tx_beat_o
);

    // Source granted most recently
    logic   last_src;
    logic   tx_ok;

    // Core can take a beat
    assign tx_ok = link_up_i && !tx_wait_i;

    // Round robin between the two completion sources
    always_comb begin
        cpl_grant_o = 2'b00;
        if (tx_ok) begin
            case (cpl_req_i)
                2'b01:   cpl_grant_o = 2'b01;
                2'b10:   cpl_grant_o = 2'b10;
                // Both pending, the other one goes first
                2'b11:   cpl_grant_o = last_src ? 2'b01 : 2'b10;
                default: cpl_grant_o = 2'b00;
            endcase
        end
    end

    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            // Source 0 wins the first tie
            last_src <= 1'b1;
        end else if (|cpl_grant_o) begin
            last_src <= cpl_grant_o[1];
        end
    end

    // Granted beat goes out for one cycle, zero otherwise
    always_ff @(posedge cfg_clk or negedge rstn) begin
        if (!rstn) begin
            tx_beat_o <= '0;
        end else if (cpl_grant_o[1]) begin
            tx_beat_o <= cpl_beat_i[1];
        end else if (cpl_grant_o[0]) begin
            tx_beat_o <= cpl_beat_i[0];
        end else begin
            tx_beat_o <= '0;
        end
    end

    a_grant_onehot: assert property (@(posedge cfg_clk) disable iff (!rstn)
        $onehot0(cpl_grant_o));

    // Sources hold a full single-beat packet while requesting
    a_grant_sends: assert property (@(posedge cfg_clk) disable iff (!rstn)
        (|cpl_grant_o) |=> (tx_beat_o.sop && tx_beat_o.eop));

endmodule

// ==== hdl/pcie_app_top.sv ====
`timescale 1ns/100ps
`include "pcie_app_defines.svh"

module pcie_app_top import pcie_app_pkg::*; (
    input  logic                    cfg_clk,
    input  logic                    rstn,
    input  tlp_beat_t               rx_beat_i,
    input  logic [`BAR_W-1:0]       rx_bardec_i,
    input  logic                    tx_wait_i,
    input  logic                    link_up_i,
    input  logic [`BUSDEV_W-1:0]    cfg_busdev_i,
    output tlp_beat_t               tx_beat_o,
    output logic [2:0]              led_o
);

    // Reset for all TLP logic, held after rstn
    logic               tlp_rstn;

    // Routed beats per BAR
    tlp_beat_t          reg_beat;
    tlp_beat_t          mem_beat;

    // Decoded requests
    tlp_req_t           reg_req;
    tlp_req_t           mem_req;

    // Completion sources, 0 is BAR1 and 1 is BAR3
    logic [1:0]         cpl_req;
    logic [1:0]         cpl_grant;
    tlp_beat_t [1:0]    cpl_beat;

    start_delay_ctrl i_start_delay (
        .cfg_clk        (cfg_clk),
        .rstn           (rstn),
        .link_up_i      (link_up_i),
        .tlp_rstn_o     (tlp_rstn),
        .led_o          (led_o)
    );

    tlp_bar_demux i_bar_demux (
        .cfg_clk        (cfg_clk),
        .rstn           (tlp_rstn),
        .beat_i         (rx_beat_i),
        .bardec_i       (rx_bardec_i),
        .reg_beat_o     (reg_beat),
        .mem_beat_o     (mem_beat)
    );

    // BAR1 path
    tlp_hdr_dec i_reg_dec (
        .cfg_clk        (cfg_clk),
        .rstn           (tlp_rstn),
        .beat_i         (reg_beat),
        .req_o          (reg_req)
    );

    bar_reg_target i_reg_target (
        .cfg_clk        (cfg_clk),
        .rstn           (tlp_rstn),
        .req_i          (reg_req),
        .busdev_i       (cfg_busdev_i),
        .link_up_i      (link_up_i),
        .cpl_req_o      (cpl_req[0]),
        .cpl_beat_o     (cpl_beat[0]),
        .cpl_grant_i    (cpl_grant[0])
    );

    // BAR3 path
    tlp_hdr_dec i_mem_dec (
        .cfg_clk        (cfg_clk),
        .rstn           (tlp_rstn),
        .beat_i         (mem_beat),
        .req_o          (mem_req)
    );

    bar_mem_target i_mem_target (
        .cfg_clk        (cfg_clk),
        .rstn           (tlp_rstn),
        .req_i          (mem_req),
        .busdev_i       (cfg_busdev_i),
        .cpl_req_o      (cpl_req[1]),
        .cpl_beat_o     (cpl_beat[1]),
        .cpl_grant_i    (cpl_grant[1])
    );

    tx_cpl_arb i_cpl_arb (
        .cfg_clk        (cfg_clk),
        .rstn           (tlp_rstn),
        .tx_wait_i      (tx_wait_i),
        .link_up_i      (link_up_i),
        .cpl_req_i      (cpl_req),
        .cpl_beat_i     (cpl_beat),
        .cpl_grant_o    (cpl_grant),
        .tx_beat_o      (tx_beat_o)
    );

endmodule

// ==== tb/tb_tlp_tasks.svh ====
`ifndef TB_TLP_TASKS_SVH
`define TB_TLP_TASKS_SVH

// Byte address for a dword offset, upper bits set to show they are ignored
function automatic logic [31:0] off_addr(input logic [7:0] off);
    return 32'hC000_0000 | {22'd0, off, 2'b00};
endfunction

// One-beat 3DW memory request, length one dword
function automatic tlp_beat_t make_req(
    input logic         wr,
    input logic [31:0]  addr,
    input logic [7:0]   tag,
    input logic [31:0]  wdata
);
    tlp_beat_t beat;
    beat.sop   = 1'b1;
    beat.eop   = 1'b1;
    // Reads carry no data dword
    beat.valid = wr ? 4'b1111 : 4'b0111;
    // TC, attributes and reserved bits zero
    beat.data[31:0]   = {(wr ? `FMT_3DW_DATA : `FMT_3DW_NODATA), `TYP_MEM, 14'h0, 10'd1};
    // Last BE none, first BE all four bytes
    beat.data[63:32]  = {REQ_ID, tag, 4'h0, 4'hF};
    beat.data[95:64]  = {addr[31:2], 2'b00};
    beat.data[127:96] = wr ? wdata : 32'h0;
    return beat;
endfunction

// Beat valid for exactly one cycle
task automatic send_beat(input tlp_beat_t beat, input logic [`BAR_W-1:0] bar);
    @(posedge cfg_clk);
    #2;
    rx_beat   = beat;
    rx_bardec = bar;
    @(posedge cfg_clk);
    #2;
    rx_beat   = '0;
    rx_bardec = '0;
endtask

// Next sop on the TX side, sampled mid-cycle
task automatic wait_cpl(output tlp_beat_t beat, output bit found);
    int n;
    found = 1'b0;
    beat  = '0;
    for (n = 0; n < 30 && !found; n++) begin
        @(negedge cfg_clk);
        if (tx_beat.sop) begin
            beat  = tx_beat;
            found = 1'b1;
        end
    end
endtask

task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        $display("FAIL %s: got 0x%h, expected 0x%h", name, got, exp);
        err_cnt++;
    end
endtask

// CplD fields against what the request asked for
task automatic check_cpl(
    input tlp_beat_t    beat,
    input logic [7:0]   exp_tag,
    input logic [6:0]   exp_la,
    input logic [31:0]  exp_data
);
    logic [31:0] dw0;
    logic [31:0] dw1;
    logic [31:0] dw2;
    dw0 = beat.data[31:0];
    dw1 = beat.data[63:32];
    dw2 = beat.data[95:64];
    check_val("tx_beat_o.sop_eop", 32'({beat.sop, beat.eop}), 32'h3);
    check_val("tx_beat_o.valid", 32'(beat.valid), 32'hF);
    check_val("tx_beat_o.fmt_type", 32'(dw0[31:24]), 32'({`FMT_3DW_DATA, `TYP_CPL}));
    check_val("tx_beat_o.length", 32'(dw0[9:0]), 32'd1);
    // Completer ID is bus/device, function 0
    check_val("tx_beat_o.cpl_id", 32'(dw1[31:16]), 32'({busdev, 3'b000}));
    check_val("tx_beat_o.byte_count", 32'(dw1[11:0]), 32'd4);
    check_val("tx_beat_o.req_id", 32'(dw2[31:16]), 32'(REQ_ID));
    check_val("tx_beat_o.tag", 32'(dw2[15:8]), 32'(exp_tag));
    check_val("tx_beat_o.lower_addr", 32'(dw2[6:0]), 32'(exp_la));
    check_val("tx_beat_o.data", beat.data[127:96], exp_data);
endtask

`endif

// ==== tb/tb_pcie_app_top.sv ====
`timescale 1ns/100ps
`include "pcie_app_defines.svh"

module tb_pcie_app_top import pcie_app_pkg::*; ();

    localparam int                  N_STIM      = 15;
    // Hung run guard in clock cycles
    localparam int                  CYCLE_LIMIT = N_STIM * 40 + 100;
    localparam logic [15:0]         REQ_ID      = 16'h0100;
    localparam logic [`BAR_W-1:0]   BAR0_HIT    = 1;
    localparam logic [`BAR_W-1:0]   BAR1_HIT    = 1 << `BAR1_BIT;
    localparam logic [`BAR_W-1:0]   BAR3_HIT    = 1 << `BAR3_BIT;

    logic                   cfg_clk = 1'b0;
    logic                   rstn;
    tlp_beat_t              rx_beat;
    logic [`BAR_W-1:0]      rx_bardec;
    logic                   tx_wait;
    logic                   link_up;
    logic [`BUSDEV_W-1:0]   busdev;
    tlp_beat_t              tx_beat;
    logic [2:0]             led;

    // Table row with the expected data of a read
    typedef struct packed {
        logic [`BAR_W-1:0]  bar;
        logic               wr;
        logic [7:0]         off;
        logic [31:0]        wdata;
        logic [31:0]        exp;
    } stim_t;

    stim_t          tbl [N_STIM];
    int             seed = 20;
    logic [31:0]    scratch_val;
    logic [7:0]     tag = 8'h00;
    int             err_cnt = 0;
    int             pass_cnt = 0;
    int             fail_cnt = 0;
    int             cycle_cnt = 0;

    `include "tb_tlp_tasks.svh"

    pcie_app_top i_dut (
        .cfg_clk        (cfg_clk),
        .rstn           (rstn),
        .rx_beat_i      (rx_beat),
        .rx_bardec_i    (rx_bardec),
        .tx_wait_i      (tx_wait),
        .link_up_i      (link_up),
        .cfg_busdev_i   (busdev),
        .tx_beat_o      (tx_beat),
        .led_o          (led)
    );

    always #20 cfg_clk = ~cfg_clk;

    always @(posedge cfg_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    task automatic load_table();
        scratch_val = $random(seed);
        // BAR3 writes, then reads back
        tbl[0]  = '{BAR3_HIT, 1'b1, 8'h03, 32'hA5A5_0003, 32'h0};
        tbl[1]  = '{BAR3_HIT, 1'b1, 8'h40, 32'h1234_5678, 32'h0};
        tbl[2]  = '{BAR3_HIT, 1'b1, 8'hFF, 32'hDEAD_BEEF, 32'h0};
        tbl[3]  = '{BAR3_HIT, 1'b0, 8'h03, 32'h0, 32'hA5A5_0003};
        tbl[4]  = '{BAR3_HIT, 1'b0, 8'h40, 32'h0, 32'h1234_5678};
        tbl[5]  = '{BAR3_HIT, 1'b0, 8'hFF, 32'h0, 32'hDEAD_BEEF};
        // BAR1 register map, ID is read only
        tbl[6]  = '{BAR1_HIT, 1'b0, 8'(`REG_ID), 32'h0, `APP_ID};
        tbl[7]  = '{BAR1_HIT, 1'b1, 8'(`REG_ID), 32'hFFFF_FFFF, 32'h0};
        tbl[8]  = '{BAR1_HIT, 1'b0, 8'(`REG_ID), 32'h0, `APP_ID};
        tbl[9]  = '{BAR1_HIT, 1'b1, 8'(`REG_SCRATCH), scratch_val, 32'h0};
        tbl[10] = '{BAR1_HIT, 1'b0, 8'(`REG_SCRATCH), 32'h0, scratch_val};
        // Link held up for the whole table
        tbl[11] = '{BAR1_HIT, 1'b0, 8'(`REG_STATUS), 32'h0, 32'h1};
        tbl[12] = '{BAR1_HIT, 1'b0, 8'h05, 32'h0, 32'h0};
        // Unrouted write must not reach the RAM
        tbl[13] = '{BAR0_HIT, 1'b1, 8'h03, 32'h0BAD_0BAD, 32'h0};
        tbl[14] = '{BAR3_HIT, 1'b0, 8'h03, 32'h0, 32'hA5A5_0003};
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (err_cnt == errs_before) begin
            $display("test %-26s pass", name);
            pass_cnt++;
        end else begin
            $display("test %-26s failed", name);
            fail_cnt++;
        end
    endtask

    initial begin
        int             i;
        int             n;
        int             errs0;
        int             got_a;
        int             got_b;
        bit             found;
        tlp_beat_t      beat;
        logic [31:0]    addr;
        logic [7:0]     tag_a;
        logic [7:0]     tag_b;

        rstn      = 1'b0;
        rx_beat   = '0;
        rx_bardec = '0;
        tx_wait   = 1'b0;
        link_up   = 1'b0;
        busdev    = 13'h0A5;
        load_table();
        repeat (2) @(posedge cfg_clk);
        #2;
        rstn = 1'b1;

        // Start delay, LEDs, TX quiet
        errs0 = err_cnt;
        @(negedge cfg_clk);
        check_val("led_o[1]", 32'(led[1]), 32'h1);
        check_val("led_o[2]", 32'(led[2]), 32'h1);
        @(posedge cfg_clk);
        #2;
        link_up = 1'b1;
        // LED follows the registered link status one edge later
        @(posedge cfg_clk);
        @(negedge cfg_clk);
        check_val("led_o[2]", 32'(led[2]), 32'h0);
        // Read sent while the TLP logic is still held must be dropped
        tag = tag + 8'd1;
        send_beat(make_req(1'b0, off_addr(8'h03), tag, 32'h0), BAR3_HIT);
        n = 0;
        while (led[1] && n < 40) begin
            check_val("tx_beat_o.sop_eop_valid",
                      32'({tx_beat.sop, tx_beat.eop, tx_beat.valid}), 32'h0);
            @(negedge cfg_clk);
            n++;
        end
        assert (!led[1]) else begin
            $display("Start delay did not end within 40 cycles");
            err_cnt++;
        end
        report_test("reset and start", errs0);

        for (i = 0; i < N_STIM; i++) begin
            errs0 = err_cnt;
            tag   = tag + 8'd1;
            addr  = off_addr(tbl[i].off);
            send_beat(make_req(tbl[i].wr, addr, tag, tbl[i].wdata), tbl[i].bar);
            if (!tbl[i].wr) begin
                wait_cpl(beat, found);
                assert (found) else begin
                    $display("No completion for the read in entry %0d", i);
                    err_cnt++;
                end
                if (found) begin
                    check_cpl(beat, tag, addr[6:0], tbl[i].exp);
                end
            end
            report_test($sformatf("entry %0d %s off 0x%h", i,
                        tbl[i].wr ? "write" : "read", tbl[i].off), errs0);
        end

        // Reads held back by tx_wait, then released
        errs0 = err_cnt;
        @(posedge cfg_clk);
        #2;
        tx_wait = 1'b1;
        tag_a = tag + 8'd1;
        tag_b = tag + 8'd2;
        tag   = tag_b;
        send_beat(make_req(1'b0, off_addr(8'(`REG_SCRATCH)), tag_a, 32'h0), BAR1_HIT);
        send_beat(make_req(1'b0, off_addr(8'h40), tag_b, 32'h0), BAR3_HIT);
        repeat (10) begin
            @(negedge cfg_clk);
            check_val("tx_beat_o.sop", 32'(tx_beat.sop), 32'h0);
        end
        @(posedge cfg_clk);
        #2;
        tx_wait = 1'b0;
        got_a = 0;
        got_b = 0;
        repeat (2) begin
            wait_cpl(beat, found);
            assert (found) else begin
                $display("Completion missing after tx_wait release");
                err_cnt++;
            end
            // Order between the two sources is not fixed
            if (found && beat.data[79:72] == tag_a) begin
                check_cpl(beat, tag_a, 7'(off_addr(8'(`REG_SCRATCH))), scratch_val);
                got_a++;
            end else if (found && beat.data[79:72] == tag_b) begin
                check_cpl(beat, tag_b, 7'(off_addr(8'h40)), 32'h1234_5678);
                got_b++;
            end else if (found) begin
                $display("Completion with unknown tag 0x%h", beat.data[79:72]);
                err_cnt++;
            end
        end
        assert (got_a == 1 && got_b == 1) else begin
            $display("Expected one completion per tag, saw %0d and %0d", got_a, got_b);
            err_cnt++;
        end
        repeat (8) begin
            @(negedge cfg_clk);
            check_val("tx_beat_o.sop", 32'(tx_beat.sop), 32'h0);
        end
        report_test("tx_wait hold and release", errs0);

        $display("Summary: %0d tests passed, %0d failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== pcie_app_top.f ====
+incdir+common
+incdir+tb
common/pcie_app_pkg.sv
hdl/start_delay_ctrl.sv
rx/tlp_bar_demux.sv
rx/tlp_hdr_dec.sv
bar/bar_mem_target.sv
bar/bar_reg_target.sv
hdl/tx_cpl_arb.sv
hdl/pcie_app_top.sv
tb/tb_pcie_app_top.sv

// ==== Makefile ====
TOOL   := verilator
FLAGS  := --binary --timing --assert -Wno-fatal
TOP    := tb_pcie_app_top
FLIST  := pcie_app_top.f
OBJDIR := obj_dir
BIN    := $(OBJDIR)/V$(TOP)
LOG    := sim.log

SRCS   := $(shell grep -v '^+' $(FLIST))
HDRS   := $(wildcard common/*.svh tb/*.svh)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q '^NO ERRORS$$' $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
